// File: axis_accumulator.sv
//======================================================================
// Stage 3: integrates mouse steps into a saturated stick position.
// A real stick or a CPU halt takes the mouse out of play
//======================================================================
`default_nettype none

module axis_accumulator
	import input_pkg::*;
(
	input  wire logic          clk_sys,
	input  wire logic          areset,
	input  wire mouse_delta_t  delta_i,
	input  wire analog_stick_t stick0_i,
	input  wire logic          cpu_halt_i,
	output axis_pos_t          pos_o,
	output logic [1:0]         buttons_o
);

	logic signed [9:0] sum_x;
	logic signed [9:0] sum_y;
	logic              override;

	function automatic logic signed [7:0] sat_axis(input logic signed [9:0] v);
		logic signed [7:0] result;
		if (v > AXIS_MAX) begin
			result = 8'(AXIS_MAX);
		end else if (v < AXIS_MIN) begin
			result = 8'(AXIS_MIN);
		end else begin
			result = v[7:0];
		end
		return result;
	endfunction

	// Two extra bits cover the largest step in either direction
	assign sum_x = {{2{pos_o.x[7]}}, pos_o.x} + {delta_i.dx[8], delta_i.dx};
	assign sum_y = {{2{pos_o.y[7]}}, pos_o.y} + {delta_i.dy[8], delta_i.dy};

	// Any deflection of the real stick counts as the player using it
	assign override = (stick0_i != '0) || cpu_halt_i;

	//==================================================================
	// Position and active flag
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			pos_o <= '0;
		end else if (override) begin
			// Wins over a step arriving on the same cycle
			pos_o <= '0;
		end else if (delta_i.valid) begin
			pos_o.x      <= sat_axis(sum_x);
			pos_o.y      <= sat_axis(sum_y);
			pos_o.active <= 1'b1;
		end
	end

	// Buttons of the most recent step
	always_ff @(posedge clk_sys) begin
		if (delta_i.valid) begin
			buttons_o <= delta_i.buttons;
		end
	end

endmodule

`default_nettype wire

// File: delta_limiter.sv
//======================================================================
// Stage 2: optional Y inversion, then a symmetric clamp of each delta
// to +/- MAX_STEP. Valid and buttons pass through one register
//======================================================================
`default_nettype none

module delta_limiter
	import input_pkg::*;
#(
	parameter int MAX_STEP = 10
) (
	input  wire logic         clk_sys,
	input  wire logic         areset,
	input  wire logic         invert_y_i,
	input  wire mouse_delta_t delta_i,
	output mouse_delta_t      delta_o
);

	logic signed [8:0] dy_dir;

	function automatic logic signed [8:0] clamp_step(input logic signed [8:0] d);
		logic signed [8:0] result;
		if (d > MAX_STEP) begin
			result = 9'(MAX_STEP);
		end else if (d < -MAX_STEP) begin
			result = 9'(-MAX_STEP);
		end else begin
			result = d;
		end
		return result;
	endfunction

	// Halved range is -128..127, so the negation still fits in 9 bits
	assign dy_dir = invert_y_i ? -delta_i.dy : delta_i.dy;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			delta_o.valid <= 1'b0;
		end else begin
			delta_o.valid <= delta_i.valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		delta_o.dx      <= clamp_step(delta_i.dx);
		delta_o.dy      <= clamp_step(dy_dir);
		delta_o.buttons <= delta_i.buttons;
	end

endmodule

`default_nettype wire

// File: flist.f
input_pkg.sv
mouse_packet_decode.sv
delta_limiter.sv
axis_accumulator.sv
port_router.sv
input_conditioning_top.sv
input_conditioning_assertions.sv
input_conditioning_tb.sv

// File: input_conditioning_assertions.sv
//======================================================================
// Concurrent checks on the stick position of the accumulator stage
// Attached by the bind at the end of this file
//======================================================================
`default_nettype none

module input_conditioning_assertions
	import input_pkg::*;
(
	input wire logic          clk_sys,
	input wire logic          areset,
	input wire mouse_delta_t  delta_i,
	input wire axis_pos_t     pos_i,
	input wire analog_stick_t stick0_i,
	input wire logic          cpu_halt_i
);

	// Reset clears position and active flag
	reset_clears: assert property (@(posedge clk_sys) areset |=> pos_i == '0)
		else $error("position or active flag not cleared by reset");

	// A real stick or a CPU halt empties the position one cycle later
	override_clears: assert property (@(posedge clk_sys) disable iff (areset)
		(stick0_i != '0 || cpu_halt_i) |=> pos_i == '0)
		else $error("position not cleared one cycle after override");

	// A step never moves an axis against its sign, so a limit cannot wrap
	axis_no_wrap: assert property (@(posedge clk_sys) disable iff (areset)
		(delta_i.valid && !(stick0_i != '0 || cpu_halt_i)) |=>
		($signed(pos_i.x) - $signed($past(pos_i.x))) * $signed($past(delta_i.dx)) >= 0 &&
		($signed(pos_i.y) - $signed($past(pos_i.y))) * $signed($past(delta_i.dy)) >= 0)
		else $error("stick axis wrapped instead of saturating");

endmodule

bind axis_accumulator input_conditioning_assertions u_assertions (
	.clk_sys    (clk_sys),
	.areset     (areset),
	.delta_i    (delta_i),
	.pos_i      (pos_o),
	.stick0_i   (stick0_i),
	.cpu_halt_i (cpu_halt_i)
);

`default_nettype wire

// File: input_conditioning_tb.sv
//======================================================================
// Directed testbench for the input conditioning pipeline
// Drives packets and controls on the falling edge, checks both ports
//======================================================================
`default_nettype none

module input_conditioning_tb
	import input_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int MAX_STEP     = 10;
	localparam int RESET_CYCLES = 4;
	// Cycle budget of each test in run order, plus margin
	localparam int TEST_CYCLES  = 10 + 50 + 80 + 20 + 40 + 30;
	localparam int WATCHDOG_CYC = RESET_CYCLES + TEST_CYCLES + 100;

	logic                clk_sys;
	logic                areset;
	mouse_packet_t       mouse;
	analog_stick_t       stick0;
	analog_stick_t       stick1;
	logic [JOY_BITS-1:0] joy0;
	logic [JOY_BITS-1:0] joy1;
	logic                invert_y;
	logic                swap;
	logic                cpu_halt;
	port_out_t           port_a;
	port_out_t           port_b;

	logic [31:0] lfsr;
	int          m_x;
	int          m_y;
	logic        m_active;
	logic [1:0]  m_buttons;
	int          checks;
	int          errors;
	int          test_errors;
	int          tests;

	input_conditioning_top #(
		.MAX_STEP (MAX_STEP)
	) dut (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.mouse_i    (mouse),
		.stick0_i   (stick0),
		.stick1_i   (stick1),
		.joy0_i     (joy0),
		.joy1_i     (joy1),
		.invert_y_i (invert_y),
		.swap_i     (swap),
		.cpu_halt_i (cpu_halt),
		.port_a_o   (port_a),
		.port_b_o   (port_b)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYC);
		$display("Simulation failed");
		$finish;
	end

	//==================================================================
	// Random source and reference model
	//==================================================================
	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = next_lfsr(lfsr);
			val = {val[6:0], lfsr[0]};
		end
	endtask

	function automatic int limit_step(input int d);
		return (d > MAX_STEP) ? MAX_STEP : ((d < -MAX_STEP) ? -MAX_STEP : d);
	endfunction

	function automatic int pin_axis(input int v);
		return (v > AXIS_MAX) ? AXIS_MAX : ((v < AXIS_MIN) ? AXIS_MIN : v);
	endfunction

	task automatic clear_model();
		m_x = 0;
		m_y = 0;
		m_active = 1'b0;
	endtask

	// Sign and byte form a 9-bit value, halved with rounding toward minus infinity
	task automatic model_step(input logic [7:0] xb, input logic xs, input logic [7:0] yb,
				input logic ys, input logic [1:0] btn);
		int dx;
		int dy;
		dx = (xs ? int'(xb) - 256 : int'(xb)) >>> 1;
		dy = (ys ? int'(yb) - 256 : int'(yb)) >>> 1;
		if (invert_y) begin
			dy = -dy;
		end
		m_x = pin_axis(m_x + limit_step(dx));
		m_y = pin_axis(m_y + limit_step(dy));
		m_active = 1'b1;
		m_buttons = btn;
	endtask

	//==================================================================
	// Drivers and checkers
	//==================================================================
	task automatic send_packet(input logic [7:0] xb, input logic xs, input logic [7:0] yb,
				input logic ys, input logic [1:0] btn);
		mouse.strobe = ~mouse.strobe;
		mouse.x_move = xb;
		mouse.y_move = yb;
		mouse.flags = {2'b00, ys, xs, 2'b00, btn};
		model_step(xb, xs, yb, ys, btn);
		@(negedge clk_sys);
	endtask

	task automatic send_random_packet();
		logic [7:0] mag_x;
		logic [7:0] mag_y;
		logic [7:0] sgn;
		logic [7:0] btn;
		rand_bits(4, mag_x);
		rand_bits(4, mag_y);
		rand_bits(2, sgn);
		rand_bits(2, btn);
		mag_x = mag_x + 8'd1;
		mag_y = mag_y + 8'd1;
		send_packet(sgn[0] ? 8'(-mag_x) : mag_x, sgn[0],
			sgn[1] ? 8'(-mag_y) : mag_y, sgn[1], btn[1:0]);
	endtask

	// Remaining edges until the last packet reaches the ports
	task automatic wait_pipeline();
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic clear_mouse();
		cpu_halt = 1'b1;
		@(negedge clk_sys);
		cpu_halt = 1'b0;
		clear_model();
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_field(input logic [31:0] got, input logic [31:0] want,
				input string what);
		checks++;
		if (got !== want) begin
			$display("CHECK FAILED at %0t: %s, expected %h got %h", $time, what, want, got);
			test_errors++;
		end
	endtask

	task automatic check_ports(input string what);
		port_out_t mouse_side;
		port_out_t stick_side;
		mouse_side.joy = joy0;
		mouse_side.stick = stick0;
		if (m_active) begin
			mouse_side.stick.x = 8'(m_x);
			mouse_side.stick.y = 8'(m_y);
			mouse_side.joy[8:7] = m_buttons;
		end
		stick_side.stick = stick1;
		stick_side.joy = joy1;
		check_field(port_a, swap ? stick_side : mouse_side, {what, " port A"});
		check_field(port_b, swap ? mouse_side : stick_side, {what, " port B"});
	endtask

	task automatic finish_test(input string name);
		tests++;
		errors += test_errors;
		if (test_errors == 0) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d mismatches", name, test_errors);
		end
		test_errors = 0;
	endtask

	//==================================================================
	// Directed tests
	//==================================================================
	task automatic test_reset_idle();
		check_ports("after reset");
		stick0 = 16'h5a3c;
		stick1 = 16'hc381;
		joy0 = 14'h2a55;
		joy1 = 14'h15aa;
		clear_model();
		repeat (2) @(negedge clk_sys);
		check_ports("idle with sticks");
		stick0 = '0;
		repeat (2) @(negedge clk_sys);
		check_ports("idle stick0 released");
		finish_test("reset and idle");
	endtask

	task automatic test_packets();
		repeat (6) begin
			send_random_packet();
			wait_pipeline();
			check_ports("single packet");
		end
		repeat (6) send_random_packet();
		wait_pipeline();
		check_ports("back-to-back burst");
		finish_test("single and back-to-back packets");
	endtask

	task automatic test_limit_saturate();
		clear_mouse();
		send_packet(8'd100, 1'b0, 8'd156, 1'b1, 2'b00);
		wait_pipeline();
		check_ports("large step");
		check_field(port_a.stick.x, 8'(MAX_STEP), "x clamped to step limit");
		repeat (19) send_packet(8'd255, 1'b0, 8'd156, 1'b1, 2'b01);
		wait_pipeline();
		check_ports("repeated steps up");
		check_field(port_a.stick, 16'h807f, "pinned at x 127 y -128");
		repeat (30) send_packet(8'd0, 1'b1, 8'd200, 1'b0, 2'b10);
		wait_pipeline();
		check_ports("repeated steps down");
		check_field(port_a.stick, 16'h7f80, "pinned at x -128 y 127");
		finish_test("limiting and saturation");
	endtask

	task automatic test_invert_y();
		clear_mouse();
		invert_y = 1'b1;
		send_packet(8'd8, 1'b0, 8'd12, 1'b0, 2'b00);
		wait_pipeline();
		check_ports("inverted positive y");
		check_field(port_a.stick, {8'(-6), 8'd4}, "y opposite, x unchanged");
		send_packet(8'(-20), 1'b1, 8'(-16), 1'b1, 2'b00);
		wait_pipeline();
		check_ports("inverted negative y");
		invert_y = 1'b0;
		finish_test("y inversion");
	endtask

	task automatic test_override_buttons();
		clear_mouse();
		send_packet(8'd6, 1'b0, 8'd6, 1'b0, 2'b11);
		wait_pipeline();
		check_ports("both buttons");
		check_field(port_a.joy[8:7], 2'b11, "buttons in bits 8 and 7");
		send_packet(8'd2, 1'b0, 8'd0, 1'b0, 2'b01);
		wait_pipeline();
		check_ports("left button");
		stick0 = 16'h0040;
		clear_model();
		repeat (2) @(negedge clk_sys);
		check_ports("stick0 override");
		stick0 = '0;
		repeat (2) @(negedge clk_sys);
		check_ports("stick0 released");
		// A still packet brings the mouse back and shows the cleared position
		send_packet(8'd0, 1'b0, 8'd0, 1'b0, 2'b00);
		wait_pipeline();
		check_field(port_a.stick, 16'h0000, "position zero after override");
		send_random_packet();
		wait_pipeline();
		check_ports("mouse back in play");
		cpu_halt = 1'b1;
		clear_model();
		repeat (2) @(negedge clk_sys);
		check_ports("cpu halt override");
		cpu_halt = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_ports("cpu halt released");
		finish_test("override and buttons");
	endtask

	task automatic test_swap();
		swap = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_ports("swap idle");
		send_random_packet();
		wait_pipeline();
		check_ports("swap with mouse");
		invert_y = 1'b1;
		send_random_packet();
		wait_pipeline();
		check_ports("swap with inversion");
		invert_y = 1'b0;
		stick0 = 16'h7f00;
		clear_model();
		repeat (2) @(negedge clk_sys);
		check_ports("swap with override");
		stick0 = '0;
		swap = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_ports("swap released");
		finish_test("port swap");
	endtask

	initial begin
		areset = 1'b1;
		mouse = '0;
		stick0 = '0;
		stick1 = '0;
		joy0 = '0;
		joy1 = '0;
		invert_y = 1'b0;
		swap = 1'b0;
		cpu_halt = 1'b0;
		lfsr = 32'ha12e37cf;
		m_buttons = 2'b00;
		checks = 0;
		errors = 0;
		test_errors = 0;
		tests = 0;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		areset = 1'b0;
		@(negedge clk_sys);
		test_reset_idle();
		test_packets();
		test_limit_saturate();
		test_invert_y();
		test_override_buttons();
		test_swap();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: input_conditioning_top.sv
//======================================================================
// Top level of the mouse and joystick conditioning pipeline
// Decode, limit, accumulate and route, one register stage each
//======================================================================
`default_nettype none

module input_conditioning_top
	import input_pkg::*;
#(
	parameter int MAX_STEP = 10
) (
	input  wire logic                clk_sys,
	input  wire logic                areset,
	input  wire mouse_packet_t       mouse_i,
	input  wire analog_stick_t       stick0_i,
	input  wire analog_stick_t       stick1_i,
	input  wire logic [JOY_BITS-1:0] joy0_i,
	input  wire logic [JOY_BITS-1:0] joy1_i,
	input  wire logic                invert_y_i,
	input  wire logic                swap_i,
	input  wire logic                cpu_halt_i,
	output port_out_t                port_a_o,
	output port_out_t                port_b_o
);

	mouse_delta_t raw_delta;
	mouse_delta_t lim_delta;
	axis_pos_t    pos;
	logic [1:0]   buttons;

	mouse_packet_decode u_decode (
		.clk_sys (clk_sys),
		.areset  (areset),
		.mouse_i (mouse_i),
		.delta_o (raw_delta)
	);

	delta_limiter #(
		.MAX_STEP (MAX_STEP)
	) u_limiter (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.invert_y_i (invert_y_i),
		.delta_i    (raw_delta),
		.delta_o    (lim_delta)
	);

	axis_accumulator u_accum (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.delta_i    (lim_delta),
		.stick0_i   (stick0_i),
		.cpu_halt_i (cpu_halt_i),
		.pos_o      (pos),
		.buttons_o  (buttons)
	);

	port_router u_router (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.pos_i     (pos),
		.buttons_i (buttons),
		.stick0_i  (stick0_i),
		.stick1_i  (stick1_i),
		.joy0_i    (joy0_i),
		.joy1_i    (joy1_i),
		.swap_i    (swap_i),
		.port_a_o  (port_a_o),
		.port_b_o  (port_b_o)
	);

endmodule

`default_nettype wire

// File: input_pkg.sv
//======================================================================
// Shared types and limits for the mouse and joystick input pipeline
// Imported by every stage, the top level and the testbench
//======================================================================
`default_nettype none

package input_pkg;

	// Digital joystick word width per controller port
	localparam int JOY_BITS = 14;

	// Emulated analog stick range, signed 8-bit
	localparam int AXIS_MIN = -128;
	localparam int AXIS_MAX = 127;

	// Raw PS/2 mouse word, strobe toggles once per packet
	// Flags: bit 0 left, bit 1 right, bit 4 x sign, bit 5 y sign
	typedef struct packed {
		logic       strobe;
		logic [7:0] y_move;
		logic [7:0] x_move;
		logic [7:0] flags;
	} mouse_packet_t;

	// One movement step, valid is a single-cycle pulse
	typedef struct packed {
		logic              valid;
		logic signed [8:0] dx;
		logic signed [8:0] dy;
		logic [1:0]        buttons;
	} mouse_delta_t;

	// Emulated stick position and mouse-in-use flag
	typedef struct packed {
		logic signed [7:0] x;
		logic signed [7:0] y;
		logic              active;
	} axis_pos_t;

	// Analog stick reading, x in the low byte
	typedef struct packed {
		logic [7:0] y;
		logic [7:0] x;
	} analog_stick_t;

	typedef struct packed {
		analog_stick_t        stick;
		logic [JOY_BITS-1:0]  joy;
	} port_out_t;

endpackage

`default_nettype wire

// File: mouse_packet_decode.sv
//======================================================================
// Stage 1: registers the raw mouse word, spots a strobe toggle and
// emits halved, sign-extended deltas with the button bits
//======================================================================
`default_nettype none

module mouse_packet_decode
	import input_pkg::*;
(
	input  wire logic          clk_sys,
	input  wire logic          areset,
	input  wire mouse_packet_t mouse_i,
	output mouse_delta_t       delta_o
);

	mouse_packet_t     packet_q;
	logic              strobe_prev;
	logic              toggle;
	logic signed [8:0] dx_full;
	logic signed [8:0] dy_full;

	// Input register and strobe history
	// Both keep loading during reset so a held strobe is not a packet
	always_ff @(posedge clk_sys) begin
		packet_q    <= mouse_i;
		strobe_prev <= packet_q.strobe;
	end

	assign toggle = packet_q.strobe != strobe_prev;

	// Sign byte plus movement byte, then halve
	assign dx_full = $signed({packet_q.flags[4], packet_q.x_move}) >>> 1;
	assign dy_full = $signed({packet_q.flags[5], packet_q.y_move}) >>> 1;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			delta_o.valid <= 1'b0;
		end else begin
			delta_o.valid <= toggle;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (toggle) begin
			delta_o.dx      <= dx_full;
			delta_o.dy      <= dy_full;
			delta_o.buttons <= packet_q.flags[1:0];
		end
	end

endmodule

`default_nettype wire

// File: port_router.sv
//======================================================================
// Stage 4: builds both controller ports. Port A carries the mouse
// while it is active, port B the second stick; swap exchanges them
//======================================================================
`default_nettype none

module port_router
	import input_pkg::*;
(
	input  wire logic                clk_sys,
	input  wire logic                areset,
	input  wire axis_pos_t           pos_i,
	input  wire logic [1:0]          buttons_i,
	input  wire analog_stick_t       stick0_i,
	input  wire analog_stick_t       stick1_i,
	input  wire logic [JOY_BITS-1:0] joy0_i,
	input  wire logic [JOY_BITS-1:0] joy1_i,
	input  wire logic                swap_i,
	output port_out_t                port_a_o,
	output port_out_t                port_b_o
);

	port_out_t mouse_port;
	port_out_t stick_port;

	// First controller, mouse or real stick
	always_comb begin
		mouse_port.joy = joy0_i;
		if (pos_i.active) begin
			mouse_port.stick.x = pos_i.x;
			mouse_port.stick.y = pos_i.y;
			// Right button on bit 8, left on bit 7
			mouse_port.joy[8:7] = buttons_i;
		end else begin
			mouse_port.stick = stick0_i;
		end
	end

	// Second controller passes straight through
	always_comb begin
		stick_port.stick = stick1_i;
		stick_port.joy   = joy1_i;
	end

	//==================================================================
	// Output registers with port swap
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			port_a_o <= '0;
			port_b_o <= '0;
		end else if (swap_i) begin
			port_a_o <= stick_port;
			port_b_o <= mouse_port;
		end else begin
			port_a_o <= mouse_port;
			port_b_o <= stick_port;
		end
	end

endmodule

`default_nettype wire
